//--- dv/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_bp_macros.svh"

module fetch_unit_tb
  import fetch_bp_pkg::*;
();

  // the directed tests finish in roughly 100 cycles after reset
  localparam int MAX_CYCLES = 2000;

  logic         CLK;
  logic         nRST;
  logic         fetch_en;
  word_t        instr;
  logic         resolve;
  logic         ex_is_branch;
  logic         ex_taken;
  word_t        ex_target;
  word_t        fetch_pc;
  fetch_entry_t head;
  logic         empty;
  logic         full;
  redirect_t    redirect;

  int cycles;
  int errors;
  int tests_run;
  int tests_bad;

  // reference predictor, counter 0 is strong not taken, 3 strong taken
  int          model_cnt [4];
  logic        model_vld [4];
  logic [27:0] model_tag [4];
  word_t       model_tgt [4];
  word_t       model_pc;

  // fetched but not yet resolved, oldest first
  word_t exp_pc_q [$];
  word_t exp_pred_q [$];
  logic  exp_taken_q [$];

  fetch_unit fetch_unit_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .fetch_en     (fetch_en),
    .instr        (instr),
    .resolve      (resolve),
    .ex_is_branch (ex_is_branch),
    .ex_taken     (ex_taken),
    .ex_target    (ex_target),
    .fetch_pc     (fetch_pc),
    .head         (head),
    .empty        (empty),
    .full         (full),
    .redirect     (redirect)
  );

  // instruction memory answers with the address itself
  assign instr = fetch_pc;

  always #2 CLK = ~CLK;

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic tick();
    @(posedge CLK);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
    begin
      $display("mismatch %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  // tag hit plus a taken counter
  function automatic logic predict_taken(input word_t pc);
    logic [1:0] idx;
    idx = pc[3:2];
    predict_taken = model_vld[idx] && (model_tag[idx] == pc[31:4]) && model_cnt[idx] >= 2;
  endfunction

  // a taken prediction gives the stored target
  function automatic word_t predict_next(input word_t pc);
    logic [1:0] idx;
    idx = pc[3:2];
    predict_next = predict_taken(pc) ? model_tgt[idx] : pc + 32'd4;
  endfunction

  function automatic void train_model(input word_t pc, input logic taken, input word_t target);
    logic [1:0] idx;
    idx = pc[3:2];
    if (taken)
    begin
      if (model_cnt[idx] < 3)
      begin
        model_cnt[idx]++;
      end
      model_vld[idx] = 1'b1;
      model_tag[idx] = pc[31:4];
      model_tgt[idx] = target;
    end
    else if (model_cnt[idx] > 0)
    begin
      model_cnt[idx]--;
    end
  endfunction

  // one push per cycle, the caller leaves room in the queue
  task automatic fetch_entries(input int n);
    for (int i = 0; i < n; i++)
    begin
      compare("fetch_pc", fetch_pc, model_pc);
      compare("full", 32'(full), 32'd0);
      exp_pc_q.push_back(model_pc);
      exp_taken_q.push_back(predict_taken(model_pc));
      exp_pred_q.push_back(predict_next(model_pc));
      model_pc = predict_next(model_pc);
      fetch_en = 1'b1;
      tick();
    end
    fetch_en = 1'b0;
  endtask

  task automatic resolve_head(input logic is_br, input logic taken, input word_t target);
    word_t pc;
    word_t pred_next;
    logic  pred_taken;
    word_t act_next;
    logic  mispredict;
    while (empty)
    begin
      tick();
    end
    if (exp_pc_q.size() == 0)
    begin
      $display("queue holds an entry that was never fetched");
      errors++;
    end
    else
    begin
      pc = exp_pc_q.pop_front();
      pred_next = exp_pred_q.pop_front();
      pred_taken = exp_taken_q.pop_front();
      compare("head.pc", head.pc, pc);
      compare("head.instr", head.instr, pc);
      compare("head.pred_taken", 32'(head.pred_taken), 32'(pred_taken));
      if (pred_taken)
      begin
        compare("head.pred_target", head.pred_target, pred_next);
      end
      act_next = (is_br && taken) ? target : pc + 32'd4;
      mispredict = (act_next != pred_next);
      resolve = 1'b1;
      ex_is_branch = is_br;
      ex_taken = taken;
      ex_target = target;
      tick();
      resolve = 1'b0;
      compare("redirect.valid", 32'(redirect.valid), 32'(mispredict));
      if (mispredict)
      begin
        compare("redirect.pc", redirect.pc, act_next);
        exp_pc_q.delete();
        exp_pred_q.delete();
        exp_taken_q.delete();
        model_pc = act_next;
      end
      if (is_br)
      begin
        train_model(pc, taken, target);
      end
      // redirect and training land on this edge
      tick();
      if (mispredict)
      begin
        compare("empty", 32'(empty), 32'd1);
      end
      compare("fetch_pc", fetch_pc, model_pc);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors > errs_at_start)
    begin
      tests_bad++;
      $display("test %s: %0d check(s) failed", name, errors - errs_at_start);
    end
    else
    begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic check_reset();
    int errs_at_start;
    errs_at_start = errors;
    compare("fetch_pc", fetch_pc, `RESET_PC);
    compare("empty", 32'(empty), 32'd1);
    compare("full", 32'(full), 32'd0);
    compare("redirect.valid", 32'(redirect.valid), 32'd0);
    report_test("reset", errs_at_start);
  endtask

  task automatic fill_and_stall();
    int errs_at_start;
    errs_at_start = errors;
    fetch_entries(4);
    compare("full", 32'(full), 32'd1);
    compare("fetch_pc", fetch_pc, 32'h0000_0110);
    fetch_en = 1'b1;
    repeat (3)
    begin
      tick();
      compare("fetch_pc", fetch_pc, 32'h0000_0110);
      compare("full", 32'(full), 32'd1);
    end
    fetch_en = 1'b0;
    compare("head.pc", head.pc, 32'h0000_0100);
    resolve_head(1'b0, 1'b0, '0);
    resolve_head(1'b0, 1'b0, '0);
    report_test("fill and back-pressure", errs_at_start);
  endtask

  task automatic mispredict_redirect();
    int errs_at_start;
    errs_at_start = errors;
    // head 0x108 was fetched as not taken
    resolve_head(1'b1, 1'b1, 32'h0000_0200);
    compare("fetch_pc", fetch_pc, 32'h0000_0200);
    fetch_entries(2);
    compare("head.pc", head.pc, 32'h0000_0200);
    resolve_head(1'b0, 1'b0, '0);
    resolve_head(1'b0, 1'b0, '0);
    report_test("mispredict redirect", errs_at_start);
  endtask

  task automatic train_loop();
    int errs_at_start;
    errs_at_start = errors;
    fetch_entries(1);
    resolve_head(1'b0, 1'b0, '0);
    // branch at 0x20c jumps to 0x300, which jumps back
    repeat (2)
    begin
      fetch_entries(1);
      resolve_head(1'b1, 1'b1, 32'h0000_0300);
      fetch_entries(1);
      resolve_head(1'b1, 1'b1, 32'h0000_020c);
    end
    fetch_entries(2);
    compare("fetch_pc", fetch_pc, 32'h0000_020c);
    resolve_head(1'b1, 1'b1, 32'h0000_0300);
    compare("head.pc", head.pc, 32'h0000_0300);
    resolve_head(1'b1, 1'b1, 32'h0000_020c);
    report_test("training", errs_at_start);
  endtask

  task automatic hysteresis();
    int errs_at_start;
    errs_at_start = errors;
    fetch_entries(1);
    compare("fetch_pc", fetch_pc, 32'h0000_0300);
    resolve_head(1'b1, 1'b0, 32'h0000_0300);
    fetch_entries(1);
    resolve_head(1'b1, 1'b1, 32'h0000_020c);
    // weakly taken still follows the target
    fetch_entries(1);
    compare("fetch_pc", fetch_pc, 32'h0000_0300);
    resolve_head(1'b1, 1'b0, 32'h0000_0300);
    fetch_entries(1);
    resolve_head(1'b1, 1'b1, 32'h0000_020c);
    fetch_entries(2);
    resolve_head(1'b1, 1'b0, 32'h0000_0300);
    compare("head.pc", head.pc, 32'h0000_0210);
    report_test("hysteresis", errs_at_start);
  endtask

  task automatic tag_alias();
    int errs_at_start;
    errs_at_start = errors;
    // 0x410 shares index 0 with the strongly taken branch at 0x210
    resolve_head(1'b1, 1'b1, 32'h0000_0410);
    fetch_entries(2);
    resolve_head(1'b0, 1'b0, '0);
    compare("head.pc", head.pc, 32'h0000_0414);
    resolve_head(1'b0, 1'b0, '0);
    report_test("tag mismatch", errs_at_start);
  endtask

  initial
  begin
    CLK = 1'b0;
    nRST = 1'b0;
    fetch_en = 1'b0;
    resolve = 1'b0;
    ex_is_branch = 1'b0;
    ex_taken = 1'b0;
    ex_target = '0;
    cycles = 0;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    model_pc = `RESET_PC;
    for (int i = 0; i < 4; i++)
    begin
      model_cnt[i] = 1;
      model_vld[i] = 1'b0;
      model_tag[i] = '0;
      model_tgt[i] = '0;
    end
    repeat (16) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_reset();
    fill_and_stall();
    mispredict_redirect();
    train_loop();
    hysteresis();
    tag_alias();
    $display("%0d tests run, %0d with errors, %0d failed checks", tests_run, tests_bad, errors);
    if (tests_bad == 0 && errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- fetch_bp.f
+incdir+include
hw/fetch_bp_pkg.sv
hw/branch_predictor.sv
hw/fetch_pc_gen.sv
hw/fetch_queue.sv
hw/branch_resolver.sv
hw/fetch_unit.sv
dv/fetch_unit_tb.sv

//--- hw/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_bp_macros.svh"

module branch_predictor
  import fetch_bp_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  word_t      lookup_pc,
  input  bp_update_t update,
  output logic       pred_taken,
  output word_t      pred_target
);

  // per-entry tables
  counter_t                cnt_q   [`BP_ENTRIES];
  logic [`BP_ENTRIES-1:0]  tag_vld_q;
  bp_tag_t                 tag_q   [`BP_ENTRIES];
  word_t                   tgt_q   [`BP_ENTRIES];

  bp_idx_t rd_idx;
  bp_tag_t rd_tag;
  bp_idx_t upd_idx;
  logic    rd_hit;

  // one saturating step in the direction of the outcome
  function automatic counter_t step_counter(counter_t cur, logic taken);
    counter_t nxt;
    nxt = cur;
    case (cur)
      STRONG_TAKEN:  nxt = taken ? STRONG_TAKEN : WEAK_TAKEN;
      WEAK_TAKEN:    nxt = taken ? STRONG_TAKEN : WEAK_NTAKEN;
      WEAK_NTAKEN:   nxt = taken ? WEAK_TAKEN   : STRONG_NTAKEN;
      STRONG_NTAKEN: nxt = taken ? WEAK_NTAKEN  : STRONG_NTAKEN;
      default:       nxt = WEAK_NTAKEN;
    endcase
    return nxt;
  endfunction

  assign rd_idx  = lookup_pc[`BP_IDX_W+1:2];
  assign rd_tag  = lookup_pc[31:4];
  assign upd_idx = update.pc[`BP_IDX_W+1:2];

  // lookup
  assign rd_hit      = tag_vld_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign pred_taken  = rd_hit &&
                       (cnt_q[rd_idx] == STRONG_TAKEN || cnt_q[rd_idx] == WEAK_TAKEN);
  assign pred_target = tgt_q[rd_idx];

  // counters and valid bits
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < `BP_ENTRIES; i++)
      begin
        cnt_q[i] <= WEAK_NTAKEN;
      end
      tag_vld_q <= '0;
    end
    else if (update.valid)
    begin
      cnt_q[upd_idx] <= step_counter(cnt_q[upd_idx], update.taken);
      if (update.taken)
      begin
        tag_vld_q[upd_idx] <= 1'b1;
      end
    end
  end

  // tag and target only allocate on a taken branch
  always_ff @(posedge CLK)
  begin
    if (update.valid && update.taken)
    begin
      tag_q[upd_idx] <= update.pc[31:4];
      tgt_q[upd_idx] <= update.target;
    end
  end

  // the entry being looked up always holds a defined counter state
  a_cnt_known: assert property (@(posedge CLK) disable iff (!nRST)
    !$isunknown(cnt_q[rd_idx]));

endmodule

//--- hw/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver
  import fetch_bp_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         resolve,
  input  logic         ex_is_branch,
  input  logic         ex_taken,
  input  word_t        ex_target,
  input  fetch_entry_t head,
  input  logic         empty,
  output logic         pop,
  output redirect_t    redirect,
  output bp_update_t   update
);

  logic  redirect_vld_q;
  word_t redirect_pc_q;
  logic  update_vld_q;
  word_t update_pc_q;
  logic  update_taken_q;
  word_t update_target_q;

  word_t seq_pc;
  word_t actual_next;
  word_t pred_next;
  logic  actual_taken;
  logic  mispredict;

  // head is wrong-path while a redirect is flushing it
  assign pop = resolve && !empty && !redirect_vld_q;

  // non-branches fall through
  assign actual_taken = ex_is_branch && ex_taken;
  assign seq_pc       = head.pc + 32'd4;
  assign actual_next  = actual_taken ? ex_target : seq_pc;
  assign pred_next    = head.pred_taken ? head.pred_target : seq_pc;
  assign mispredict   = (actual_next != pred_next);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      redirect_vld_q <= 1'b0;
      update_vld_q   <= 1'b0;
    end
    else
    begin
      redirect_vld_q <= pop && mispredict;
      update_vld_q   <= pop && ex_is_branch;
    end
  end

  always_ff @(posedge CLK)
  begin
    redirect_pc_q   <= actual_next;
    update_pc_q     <= head.pc;
    update_taken_q  <= actual_taken;
    update_target_q <= ex_target;
  end

  assign redirect = '{valid: redirect_vld_q, pc: redirect_pc_q};
  assign update   = '{valid: update_vld_q, pc: update_pc_q,
                      taken: update_taken_q, target: update_target_q};

  // a redirect is a single-cycle pulse
  a_redirect_pulse: assert property (@(posedge CLK) disable iff (!nRST)
    redirect_vld_q |=> !redirect_vld_q);

endmodule

//--- hw/fetch_bp_pkg.sv
`include "fetch_bp_macros.svh"

package fetch_bp_pkg;

  // instruction word or byte address
  typedef logic [31:0] word_t;

  // predictor index, pc[3:2]
  typedef logic [`BP_IDX_W-1:0] bp_idx_t;

  // predictor tag, pc[31:4]
  typedef logic [27:0] bp_tag_t;

  // two-bit saturating counter
  typedef enum logic [1:0] {
    STRONG_TAKEN,
    WEAK_TAKEN,
    WEAK_NTAKEN,
    STRONG_NTAKEN
  } counter_t;

  // one fetched instruction with its prediction, 97 bits
  typedef struct packed {
    word_t pc;
    word_t instr;
    logic  pred_taken;
    word_t pred_target;
  } fetch_entry_t;

  // training request from the resolver
  typedef struct packed {
    logic  valid;
    word_t pc;
    logic  taken;
    word_t target;
  } bp_update_t;

  // fetch redirect after a mispredict
  typedef struct packed {
    logic  valid;
    word_t pc;
  } redirect_t;

endpackage

//--- hw/fetch_pc_gen.sv
`timescale 1ns/1ps
`include "fetch_bp_macros.svh"

module fetch_pc_gen
  import fetch_bp_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         fetch_en,
  input  word_t        instr,
  input  logic         pred_taken,
  input  word_t        pred_target,
  input  logic         full,
  input  redirect_t    redirect,
  output word_t        fetch_pc,
  output logic         push,
  output fetch_entry_t push_entry
);

  word_t pc_q;
  word_t pc_next;
  word_t seq_pc;

  assign seq_pc = pc_q + 32'd4;

  // no fetch into a full queue or on the flush edge
  assign push = fetch_en && !full && !redirect.valid;

  assign push_entry = '{
    pc:          pc_q,
    instr:       instr,
    pred_taken:  pred_taken,
    pred_target: pred_target
  };

  // redirect wins over the prediction, stall holds the pc
  always_comb
  begin
    pc_next = pc_q;
    if (redirect.valid)
    begin
      pc_next = redirect.pc;
    end
    else if (push)
    begin
      pc_next = pred_taken ? pred_target : seq_pc;
    end
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc_q <= `RESET_PC;
    end
    else
    begin
      pc_q <= pc_next;
    end
  end

  assign fetch_pc = pc_q;

endmodule

//--- hw/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_bp_macros.svh"

module fetch_queue
  import fetch_bp_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         push,
  input  fetch_entry_t push_entry,
  input  logic         pop,
  input  logic         flush,
  output fetch_entry_t head,
  output logic         full,
  output logic         empty
);

  fetch_entry_t mem [`FQ_DEPTH];

  logic [`FQ_PTR_W-1:0] wr_ptr_q;
  logic [`FQ_PTR_W-1:0] rd_ptr_q;
  // one extra bit so a full queue is distinct from an empty one
  logic [`FQ_PTR_W:0]   count_q;

  logic do_push;
  logic do_pop;

  assign full  = (count_q == (`FQ_PTR_W+1)'(`FQ_DEPTH));
  assign empty = (count_q == '0);

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign head = mem[rd_ptr_q];

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (flush)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (do_push && !flush)
    begin
      mem[wr_ptr_q] <= push_entry;
    end
  end

  // producer must respect full, resolver must respect empty
  a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
    push |-> !full);
  a_no_pop_empty: assert property (@(posedge CLK) disable iff (!nRST)
    pop |-> !empty);

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
  import fetch_bp_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         fetch_en,
  input  word_t        instr,
  input  logic         resolve,
  input  logic         ex_is_branch,
  input  logic         ex_taken,
  input  word_t        ex_target,
  output word_t        fetch_pc,
  output fetch_entry_t head,
  output logic         empty,
  output logic         full,
  output redirect_t    redirect
);

  // lookup path
  logic         pred_taken;
  word_t        pred_target;

  // queue traffic
  logic         push;
  fetch_entry_t push_entry;
  logic         pop;

  // training path
  bp_update_t   bp_update;

  branch_predictor branch_predictor_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .lookup_pc   (fetch_pc),
    .update      (bp_update),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  fetch_pc_gen fetch_pc_gen_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .fetch_en    (fetch_en),
    .instr       (instr),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .full        (full),
    .redirect    (redirect),
    .fetch_pc    (fetch_pc),
    .push        (push),
    .push_entry  (push_entry)
  );

  // flushed by the same redirect that reloads the pc
  fetch_queue fetch_queue_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .flush      (redirect.valid),
    .head       (head),
    .full       (full),
    .empty      (empty)
  );

  branch_resolver branch_resolver_inst (
    .CLK          (CLK),
    .nRST         (nRST),
    .resolve      (resolve),
    .ex_is_branch (ex_is_branch),
    .ex_taken     (ex_taken),
    .ex_target    (ex_target),
    .head         (head),
    .empty        (empty),
    .pop          (pop),
    .redirect     (redirect),
    .update       (bp_update)
  );

endmodule

//--- include/fetch_bp_macros.svh
`ifndef FETCH_BP_MACROS_SVH
`define FETCH_BP_MACROS_SVH

// predictor table geometry, indexed by pc[3:2]
`define BP_ENTRIES 4
`define BP_IDX_W   2

// fetch queue geometry
`define FQ_DEPTH   4
`define FQ_PTR_W   2

// first fetch address out of reset
`define RESET_PC   32'h0000_0100

`endif

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f fetch_bp.f \
  --top-module fetch_unit_tb \
  --Mdir obj_dir \
  -o fetch_unit_sim

out=$(./obj_dir/fetch_unit_sim)
echo "$out"
echo "$out" | grep -q "All tests passed"
